// File: source/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// sign sits above the magnitude in a word
`define CORE_MAG_W      30
`define CORE_ADDR_W     12
`define CORE_OP_W       6

// output device
`define CORE_DIGIT_W    5
`define CORE_OCT_DIGITS 10    // 3 bits each

`define CORE_MEM_DEPTH  4096

`endif

// File: source/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    typedef logic [`CORE_MAG_W-1:0]   mag_t;
    typedef logic [`CORE_MAG_W:0]     word_t;    // {sign, magnitude}
    typedef logic [`CORE_ADDR_W-1:0]  addr_t;
    typedef logic [`CORE_OP_W-1:0]    op_code_t;
    typedef logic [`CORE_DIGIT_W-1:0] digit_t;

    typedef enum logic [2:0] {
        ORD_STOP,
        ORD_ADD,
        ORD_SUB,
        ORD_AND,
        ORD_WRITE,
        ORD_OUTPUT
    } order_t;

    typedef enum logic [2:0] {
        PU_IDLE = 3'd0,
        PU_FETCH,
        PU_DECODE,
        PU_READ1,
        PU_READ2,
        PU_EXEC,
        PU_WRITE,
        PU_OUTPUT
    } pu_state_t;

endpackage

// File: source/pulse_unit.sv
`timescale 1ns/10ps

module pulse_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pnl_start_pulse,
    input  logic                pnl_do_arr_c,
    input  logic                pnl_do_arr_strt,
    input  logic                pnl_do_arr_sel,
    input  logic                pnl_do_store,
    input  logic                pnl_do_fetch,
    input  core_pkg::order_t    order,
    input  logic                read_reply,
    input  logic                io_done,
    output logic                do_code_to_op,
    output logic                do_inc_strt,
    output logic                do_arr_strt,
    output logic                do_arr_sel,
    output logic                do_strt_to_sel,
    output logic                do_addr1_to_sel,
    output logic                do_addr2_to_sel,
    output logic                do_arr_c,
    output logic                do_mem_to_a,
    output logic                do_mem_to_b,
    output logic                do_mem_to_c,
    output logic                do_execute,
    output logic                mem_read,
    output logic                mem_write,
    output logic                io_start,
    output core_pkg::pu_state_t pu_state
);

    core_pkg::pu_state_t nxt_state;
    logic [1:0]          step;         // sub-cycle within a state
    logic [1:0]          nxt_step;
    logic                pnl_fetch;    // READ1 serves a panel fetch
    logic                idle;
    logic                read2;

    assign idle  = (pu_state == core_pkg::PU_IDLE);
    assign read2 = (pu_state == core_pkg::PU_READ2);

    // panel loads pass only while idle
    assign do_arr_c    = idle & pnl_do_arr_c;
    assign do_arr_strt = idle & pnl_do_arr_strt;
    assign do_arr_sel  = idle & pnl_do_arr_sel;

    always_comb begin
        nxt_state       = pu_state;
        nxt_step        = 2'd0;
        do_code_to_op   = 1'b0;
        do_inc_strt     = 1'b0;
        do_strt_to_sel  = 1'b0;
        do_addr1_to_sel = 1'b0;
        do_addr2_to_sel = 1'b0;
        do_mem_to_a     = 1'b0;
        do_mem_to_b     = 1'b0;
        do_mem_to_c     = 1'b0;
        do_execute      = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        io_start        = 1'b0;
        case (pu_state)
            core_pkg::PU_IDLE: begin
                mem_write = pnl_do_store;    // M[sel] := C
                if (pnl_start_pulse) begin
                    nxt_state = core_pkg::PU_FETCH;
                end else if (pnl_do_fetch) begin
                    nxt_state = core_pkg::PU_READ1;
                    nxt_step  = 2'd1;        // sel already loaded from panel
                end
            end
            core_pkg::PU_FETCH: begin
                if (step == 2'd0) begin
                    do_strt_to_sel = 1'b1;
                    nxt_step       = 2'd1;
                end else begin
                    mem_read  = 1'b1;
                    nxt_state = core_pkg::PU_DECODE;
                end
            end
            core_pkg::PU_DECODE: begin
                if (step == 2'd0) begin
                    if (read_reply) begin
                        do_code_to_op = 1'b1;
                        do_inc_strt   = 1'b1;
                        nxt_step      = 2'd1;
                    end
                end else begin
                    case (order)
                        core_pkg::ORD_ADD,
                        core_pkg::ORD_SUB,
                        core_pkg::ORD_AND:    nxt_state = core_pkg::PU_READ1;
                        core_pkg::ORD_WRITE:  nxt_state = core_pkg::PU_WRITE;
                        core_pkg::ORD_OUTPUT: nxt_state = core_pkg::PU_OUTPUT;
                        default:              nxt_state = core_pkg::PU_IDLE;
                    endcase
                end
            end
            core_pkg::PU_READ1, core_pkg::PU_READ2: begin
                case (step)
                    2'd0: begin
                        do_addr1_to_sel = !read2;
                        do_addr2_to_sel = read2;
                        nxt_step        = 2'd1;
                    end
                    2'd1: begin
                        mem_read = 1'b1;
                        nxt_step = 2'd2;
                    end
                    default: begin
                        if (read_reply) begin
                            do_mem_to_c = pnl_fetch;
                            do_mem_to_a = !pnl_fetch && !read2;
                            do_mem_to_b = read2;
                            if (pnl_fetch) begin
                                nxt_state = core_pkg::PU_IDLE;
                            end else if (read2) begin
                                nxt_state = core_pkg::PU_EXEC;
                            end else begin
                                nxt_state = core_pkg::PU_READ2;
                            end
                        end else begin
                            nxt_step = step;
                        end
                    end
                endcase
            end
            core_pkg::PU_EXEC: begin
                do_execute = 1'b1;
                nxt_state  = core_pkg::PU_FETCH;
            end
            core_pkg::PU_WRITE: begin
                if (step == 2'd0) begin
                    do_addr2_to_sel = 1'b1;
                    nxt_step        = 2'd1;
                end else begin
                    mem_write = 1'b1;
                    nxt_state = core_pkg::PU_FETCH;
                end
            end
            default: begin    // PU_OUTPUT
                if (step == 2'd0) begin
                    io_start = 1'b1;
                    nxt_step = 2'd1;
                end else if (io_done) begin
                    nxt_state = core_pkg::PU_FETCH;
                end else begin
                    nxt_step = step;    // device may hold us here
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pu_state  <= core_pkg::PU_IDLE;
            step      <= 2'd0;
            pnl_fetch <= 1'b0;
        end else begin
            pu_state <= nxt_state;
            step     <= nxt_step;
            if (idle) begin
                pnl_fetch <= pnl_do_fetch & ~pnl_start_pulse;
            end
        end
    end

endmodule

// File: source/operator.sv
`timescale 1ns/10ps

module operator (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               do_code_to_op,
    input  core_pkg::mag_t     read_data,
    output core_pkg::order_t   order,
    output core_pkg::op_code_t op_code,
    output core_pkg::addr_t    addr1,
    output core_pkg::addr_t    addr2
);

    // magnitude holds op | addr1 | addr2
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_code <= '0;
            addr1   <= '0;
            addr2   <= '0;
        end else if (do_code_to_op) begin
            {op_code, addr1, addr2} <= read_data;
        end
    end

    always_comb begin
        case (op_code)
            6'd1:    order = core_pkg::ORD_ADD;
            6'd2:    order = core_pkg::ORD_SUB;
            6'd3:    order = core_pkg::ORD_AND;
            6'd4:    order = core_pkg::ORD_WRITE;
            6'd5:    order = core_pkg::ORD_OUTPUT;
            default: order = core_pkg::ORD_STOP;    // unknown codes halt too
        endcase
    end

endmodule

// File: source/address_unit.sv
`timescale 1ns/10ps

module address_unit (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            do_arr_strt,
    input  core_pkg::addr_t arr_strt_value,
    input  logic            do_inc_strt,
    input  logic            do_arr_sel,
    input  core_pkg::addr_t arr_sel_value,
    input  logic            do_strt_to_sel,
    input  logic            do_addr1_to_sel,
    input  logic            do_addr2_to_sel,
    input  core_pkg::addr_t addr1,
    input  core_pkg::addr_t addr2,
    output core_pkg::addr_t strt_value,
    output core_pkg::addr_t sel_value
);

    // start register acts as the program counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            strt_value <= '0;
        end else if (do_arr_strt) begin
            strt_value <= arr_strt_value;
        end else if (do_inc_strt) begin
            strt_value <= strt_value + 1'b1;    // wraps past top of memory
        end
    end

    // select register addresses memory
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_value <= '0;
        end else if (do_arr_sel) begin
            sel_value <= arr_sel_value;
        end else if (do_strt_to_sel) begin
            sel_value <= strt_value;
        end else if (do_addr1_to_sel) begin
            sel_value <= addr1;
        end else if (do_addr2_to_sel) begin
            sel_value <= addr2;
        end
    end

endmodule

// File: source/arith_unit.sv
`timescale 1ns/10ps

module arith_unit (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             do_arr_c,
    input  core_pkg::word_t  arr_reg_c_value,
    input  logic             do_mem_to_a,
    input  logic             do_mem_to_b,
    input  logic             do_mem_to_c,
    input  logic             do_execute,
    input  core_pkg::order_t order,
    input  core_pkg::word_t  read_data,
    output core_pkg::word_t  reg_c_value
);

    core_pkg::word_t reg_a;
    core_pkg::word_t reg_b;
    core_pkg::mag_t  a_mag;
    core_pkg::mag_t  b_mag;
    core_pkg::mag_t  res_mag;
    logic            a_sign;
    logic            b_raw_sign;
    logic            b_sign;
    logic            res_sign;

    assign {a_sign, a_mag}     = reg_a;
    assign {b_raw_sign, b_mag} = reg_b;
    assign b_sign = b_raw_sign ^ (order == core_pkg::ORD_SUB);    // SUB adds -B

    always_comb begin
        if (order == core_pkg::ORD_AND) begin
            res_sign = a_sign & b_sign;
            res_mag  = a_mag & b_mag;
        end else if (a_sign == b_sign) begin
            res_sign = a_sign;
            res_mag  = a_mag + b_mag;    // wraps mod 2^30
        end else if (a_mag >= b_mag) begin
            res_sign = a_sign;
            res_mag  = a_mag - b_mag;
        end else begin
            // larger magnitude sets the sign
            res_sign = b_sign;
            res_mag  = b_mag - a_mag;
        end
    end

    always_ff @(posedge clk) begin
        if (do_mem_to_a) begin
            reg_a <= read_data;
        end
        if (do_mem_to_b) begin
            reg_b <= read_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_c_value <= '0;
        end else if (do_arr_c) begin
            reg_c_value <= arr_reg_c_value;
        end else if (do_mem_to_c) begin
            reg_c_value <= read_data;
        end else if (do_execute) begin
            reg_c_value <= {res_sign & (|res_mag), res_mag};    // no negative zero
        end
    end

endmodule

// File: source/memory.sv
`timescale 1ns/10ps
`include "core_config.svh"

module memory (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            mem_read,
    input  logic            mem_write,
    input  core_pkg::addr_t sel_value,
    input  core_pkg::word_t write_data,
    output core_pkg::word_t read_data,
    output logic            read_reply
);

    core_pkg::word_t mem [`CORE_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[sel_value] <= write_data;
        end
        if (mem_read) begin
            read_data <= mem[sel_value];
        end
    end

    // marks the cycle read_data is valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_reply <= 1'b0;
        end else begin
            read_reply <= mem_read;
        end
    end

endmodule

// File: source/io_unit.sv
`timescale 1ns/10ps

module io_unit (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             io_start,
    input  core_pkg::word_t  reg_c_value,
    input  logic             dev_output_ack,
    output logic             dev_output_rdy,
    output core_pkg::digit_t dev_output_data,
    output logic             io_done
);

    localparam int         MAG_W = $bits(core_pkg::mag_t);
    localparam logic [3:0] XFERS = 4'(MAG_W / 3 + 1);    // sign first and then the octal digits

    core_pkg::mag_t shift_mag;
    logic           sign;
    logic [3:0]     xfer_cnt;    // acknowledged transfers
    logic           busy;

    // transfer 0 carries the sign on bit 0
    assign dev_output_data = (xfer_cnt == '0) ? core_pkg::digit_t'(sign)
                                              : core_pkg::digit_t'(shift_mag[MAG_W-1 -: 3]);

    always_ff @(posedge clk) begin
        if (io_start) begin
            {sign, shift_mag} <= reg_c_value;
        end else if (dev_output_rdy && dev_output_ack && xfer_cnt != '0) begin
            shift_mag <= shift_mag << 3;    // next digit to the top
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy           <= 1'b0;
            dev_output_rdy <= 1'b0;
            xfer_cnt       <= '0;
            io_done        <= 1'b0;
        end else begin
            io_done <= 1'b0;
            if (io_start) begin
                busy     <= 1'b1;
                xfer_cnt <= '0;
            end else if (dev_output_rdy) begin
                if (dev_output_ack) begin
                    dev_output_rdy <= 1'b0;
                    xfer_cnt       <= xfer_cnt + 1'b1;
                end
            end else if (busy && !dev_output_ack) begin
                // ack is low again so the previous transfer is closed
                if (xfer_cnt == XFERS) begin
                    busy    <= 1'b0;
                    io_done <= 1'b1;
                end else begin
                    dev_output_rdy <= 1'b1;
                end
            end
        end
    end

endmodule

// File: source/core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic                clk,
    input  logic                arst_n,

    output logic                dev_output_rdy,        // handshake
    input  logic                dev_output_ack,        // handshake
    output core_pkg::digit_t    dev_output_data,

    input  logic                pnl_start_pulse,       // pulse
    input  logic                pnl_do_arr_c,          // pulse
    input  core_pkg::word_t     pnl_arr_reg_c_value,
    input  logic                pnl_do_arr_strt,       // pulse
    input  core_pkg::addr_t     pnl_arr_strt_value,
    input  logic                pnl_do_arr_sel,        // pulse
    input  core_pkg::addr_t     pnl_arr_sel_value,
    input  logic                pnl_do_store,          // pulse
    input  logic                pnl_do_fetch,          // pulse

    output core_pkg::op_code_t  pnl_op_code,
    output core_pkg::addr_t     pnl_strt_value,
    output core_pkg::addr_t     pnl_sel_value,
    output core_pkg::word_t     pnl_reg_c_value,
    output core_pkg::pu_state_t pnl_pu_state
);

    // sequencer strobes
    logic do_code_to_op, do_inc_strt, do_arr_strt, do_arr_sel;
    logic do_strt_to_sel, do_addr1_to_sel, do_addr2_to_sel;
    logic do_arr_c, do_mem_to_a, do_mem_to_b, do_mem_to_c, do_execute;
    logic mem_read, mem_write, io_start;

    logic               read_reply;
    logic               io_done;
    core_pkg::order_t   order;
    core_pkg::addr_t    addr1;
    core_pkg::addr_t    addr2;
    core_pkg::word_t    read_data;

    pulse_unit u_pulse_unit (
        .clk, .arst_n,
        .pnl_start_pulse, .pnl_do_arr_c, .pnl_do_arr_strt,
        .pnl_do_arr_sel, .pnl_do_store, .pnl_do_fetch,
        .order, .read_reply, .io_done,
        .do_code_to_op, .do_inc_strt, .do_arr_strt, .do_arr_sel,
        .do_strt_to_sel, .do_addr1_to_sel, .do_addr2_to_sel,
        .do_arr_c, .do_mem_to_a, .do_mem_to_b, .do_mem_to_c, .do_execute,
        .mem_read, .mem_write, .io_start,
        .pu_state         ( pnl_pu_state )
    );

    operator u_operator (
        .clk, .arst_n,
        .do_code_to_op,
        .read_data        ( read_data[$bits(core_pkg::mag_t)-1:0] ),    // sign dropped
        .order,
        .op_code          ( pnl_op_code ),
        .addr1, .addr2
    );

    address_unit u_address_unit (
        .clk, .arst_n,
        .do_arr_strt,
        .arr_strt_value   ( pnl_arr_strt_value ),
        .do_inc_strt,
        .do_arr_sel,
        .arr_sel_value    ( pnl_arr_sel_value ),
        .do_strt_to_sel, .do_addr1_to_sel, .do_addr2_to_sel,
        .addr1, .addr2,
        .strt_value       ( pnl_strt_value ),
        .sel_value        ( pnl_sel_value )
    );

    arith_unit u_arith_unit (
        .clk, .arst_n,
        .do_arr_c,
        .arr_reg_c_value  ( pnl_arr_reg_c_value ),
        .do_mem_to_a, .do_mem_to_b, .do_mem_to_c, .do_execute,
        .order, .read_data,
        .reg_c_value      ( pnl_reg_c_value )
    );

    memory u_memory (
        .clk, .arst_n,
        .mem_read, .mem_write,
        .sel_value        ( pnl_sel_value ),
        .write_data       ( pnl_reg_c_value ),
        .read_data, .read_reply
    );

    io_unit u_io_unit (
        .clk, .arst_n,
        .io_start,
        .reg_c_value      ( pnl_reg_c_value ),
        .dev_output_ack, .dev_output_rdy, .dev_output_data,
        .io_done
    );

endmodule

// File: tb/core_top_sva.sv
`timescale 1ns/10ps

module core_top_sva (
    input logic                clk,
    input logic                arst_n,
    input logic                dev_output_rdy,
    input logic                dev_output_ack,
    input core_pkg::digit_t    dev_output_data,
    input core_pkg::pu_state_t pnl_pu_state
);

    // rdy held until the device answers
    rdy_held: assert property (@(posedge clk) disable iff (!arst_n)
        dev_output_rdy && !dev_output_ack |=> dev_output_rdy)
        else $error("dev_output_rdy dropped before dev_output_ack");

    // no new transfer while the old ack is still up
    rdy_waits_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
        !dev_output_rdy && dev_output_ack |=> !dev_output_rdy)
        else $error("dev_output_rdy rose while dev_output_ack was high");

    data_stable: assert property (@(posedge clk) disable iff (!arst_n)
        $past(dev_output_rdy) && dev_output_rdy |-> $stable(dev_output_data))
        else $error("dev_output_data changed while dev_output_rdy was high");

    idle_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> pnl_pu_state == core_pkg::PU_IDLE)
        else $error("sequencer not idle when reset was released");

endmodule

bind core_top core_top_sva u_sva (
    .clk             ( clk ),
    .arst_n          ( arst_n ),
    .dev_output_rdy  ( dev_output_rdy ),
    .dev_output_ack  ( dev_output_ack ),
    .dev_output_data ( dev_output_data ),
    .pnl_pu_state    ( pnl_pu_state )
);

// File: tb/core_top_tb.sv
`timescale 1ns/10ps
`include "core_config.svh"

module core_top_tb;

    localparam int TIMEOUT_CYCLES = 20000;

    logic                clk = 1'b0;
    logic                arst_n;
    logic                dev_output_rdy;
    logic                dev_output_ack = 1'b0;
    core_pkg::digit_t    dev_output_data;
    logic                pnl_start_pulse;
    logic                pnl_do_arr_c;
    core_pkg::word_t     pnl_arr_reg_c_value;
    logic                pnl_do_arr_strt;
    core_pkg::addr_t     pnl_arr_strt_value;
    logic                pnl_do_arr_sel;
    core_pkg::addr_t     pnl_arr_sel_value;
    logic                pnl_do_store;
    logic                pnl_do_fetch;
    core_pkg::op_code_t  pnl_op_code;
    core_pkg::addr_t     pnl_strt_value;
    core_pkg::addr_t     pnl_sel_value;
    core_pkg::word_t     pnl_reg_c_value;
    core_pkg::pu_state_t pnl_pu_state;

    logic [31:0]      lfsr_state = 32'ha2a0;
    int               cycles = 0;
    core_pkg::digit_t got_digits[$];    // filled by the device model

    core_top u_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // device side of the output handshake
    always begin
        @(posedge clk);
        if (arst_n && dev_output_rdy && !dev_output_ack) begin
            got_digits.push_back(dev_output_data);
            wait_cycles(int'(rand_bits(3)));
            dev_output_ack <= 1'b1;
            do begin
                @(posedge clk);
            end while (dev_output_rdy);
            wait_cycles(int'(rand_bits(3)));
            dev_output_ack <= 1'b0;
        end
    end

    function automatic core_pkg::word_t make_instr(input core_pkg::op_code_t op,
                                                   input core_pkg::addr_t a1,
                                                   input core_pkg::addr_t a2);
        return {1'(rand_bits(1)), op, a1, a2};    // sign bit is don't care
    endfunction

    function automatic core_pkg::word_t rand_word();
        return {1'(rand_bits(1)), core_pkg::mag_t'(rand_bits(`CORE_MAG_W))};
    endfunction

    // signed sum with wrapped magnitude and positive zero
    function automatic core_pkg::word_t model_add_sub(input core_pkg::word_t a,
                                                      input core_pkg::word_t b,
                                                      input logic sub);
        longint         va;
        longint         vb;
        longint         s;
        core_pkg::mag_t m;
        va = longint'(a[`CORE_MAG_W-1:0]);
        vb = longint'(b[`CORE_MAG_W-1:0]);
        if (a[`CORE_MAG_W]) begin
            va = -va;
        end
        if (b[`CORE_MAG_W] ^ sub) begin
            vb = -vb;
        end
        s = va + vb;
        m = core_pkg::mag_t'(s < 0 ? -s : s);
        return {(s < 0) && (m != '0), m};
    endfunction

    function automatic core_pkg::word_t model_and(input core_pkg::word_t a,
                                                  input core_pkg::word_t b);
        core_pkg::word_t r;
        r = a & b;
        if (r[`CORE_MAG_W-1:0] == '0) begin
            r[`CORE_MAG_W] = 1'b0;
        end
        return r;
    endfunction

    task automatic load_sel(input core_pkg::addr_t a);
        pnl_arr_sel_value <= a;
        pnl_do_arr_sel    <= 1'b1;
        @(posedge clk);
        pnl_do_arr_sel    <= 1'b0;
    endtask

    task automatic load_c(input core_pkg::word_t w);
        pnl_arr_reg_c_value <= w;
        pnl_do_arr_c        <= 1'b1;
        @(posedge clk);
        pnl_do_arr_c        <= 1'b0;
    endtask

    task automatic load_strt(input core_pkg::addr_t a);
        pnl_arr_strt_value <= a;
        pnl_do_arr_strt    <= 1'b1;
        @(posedge clk);
        pnl_do_arr_strt    <= 1'b0;
    endtask

    task automatic wait_idle;
        do begin
            @(posedge clk);
        end while (pnl_pu_state != core_pkg::PU_IDLE);
    endtask

    task automatic store_word(input core_pkg::addr_t a, input core_pkg::word_t w);
        load_sel(a);
        load_c(w);
        pnl_do_store <= 1'b1;
        @(posedge clk);
        pnl_do_store <= 1'b0;
    endtask

    task automatic fetch_word(input core_pkg::addr_t a, output core_pkg::word_t w);
        load_sel(a);
        pnl_do_fetch <= 1'b1;
        @(posedge clk);
        pnl_do_fetch <= 1'b0;
        wait_idle();
        check("pnl_sel_value", 64'(pnl_sel_value), 64'(a));
        w = pnl_reg_c_value;
    endtask

    task automatic run_program(input core_pkg::addr_t start);
        load_strt(start);
        pnl_start_pulse <= 1'b1;
        @(posedge clk);
        pnl_start_pulse <= 1'b0;
        wait_idle();
    endtask

    task automatic check_reset_state;
        check("pnl_pu_state", 64'(pnl_pu_state), 64'(core_pkg::PU_IDLE));
        check("dev_output_rdy", 64'(dev_output_rdy), 64'd0);
        check("pnl_reg_c_value", 64'(pnl_reg_c_value), 64'd0);
        check("pnl_strt_value", 64'(pnl_strt_value), 64'd0);
        check("pnl_sel_value", 64'(pnl_sel_value), 64'd0);
        check("pnl_op_code", 64'(pnl_op_code), 64'd0);
    endtask

    task automatic store_fetch_roundtrip;
        core_pkg::addr_t addrs[16];
        core_pkg::word_t words[16];
        core_pkg::addr_t a;
        core_pkg::word_t w;
        logic            dup;
        for (int i = 0; i < 16; i++) begin
            do begin
                a   = core_pkg::addr_t'(rand_bits(`CORE_ADDR_W));
                dup = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (addrs[j] == a) begin
                        dup = 1'b1;
                    end
                end
            end while (dup);
            addrs[i] = a;
            words[i] = rand_word();
            store_word(addrs[i], words[i]);
        end
        for (int i = 15; i >= 0; i--) begin    // reverse order
            fetch_word(addrs[i], w);
            check("pnl_reg_c_value", 64'(w), 64'(words[i]));
        end
    endtask

    task automatic add_sub_programs;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::addr_t prog;
        core_pkg::addr_t d1;
        logic            sub;
        for (int i = 0; i < 8; i++) begin
            sub  = i[0];
            prog = 12'h800 + core_pkg::addr_t'(4 * i);
            d1   = 12'h900 + core_pkg::addr_t'(2 * i);
            a    = rand_word();
            b    = rand_word();
            if (i == 5) begin
                a[`CORE_MAG_W] = 1'b1;
                b = a;    // zero result from a negative operand
            end else if (i == 6) begin
                a = {1'b0, {`CORE_MAG_W{1'b1}}};
                b = {1'b0, core_pkg::mag_t'(rand_bits(`CORE_MAG_W)) | 30'd1};
            end
            store_word(d1, a);
            store_word(d1 + 12'd1, b);
            store_word(prog, make_instr(sub ? 6'd2 : 6'd1, d1, d1 + 12'd1));
            store_word(prog + 12'd1, make_instr(6'd0, 12'd0, 12'd0));
            run_program(prog);
            check("pnl_reg_c_value", 64'(pnl_reg_c_value), 64'(model_add_sub(a, b, sub)));
            check("pnl_strt_value", 64'(pnl_strt_value), 64'(prog + 12'd2));
        end
    endtask

    task automatic and_write_programs;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t c;
        core_pkg::word_t w;
        a = rand_word();
        b = rand_word();
        store_word(12'ha00, a);
        store_word(12'ha01, b);
        store_word(12'ha10, '0);
        store_word(12'ha20, make_instr(6'd3, 12'ha00, 12'ha01));
        store_word(12'ha21, make_instr(6'd4, 12'h000, 12'ha10));
        store_word(12'ha22, make_instr(6'd0, 12'h000, 12'h000));
        run_program(12'ha20);
        check("pnl_strt_value", 64'(pnl_strt_value), 64'(12'ha23));
        check("pnl_op_code", 64'(pnl_op_code), 64'd0);
        fetch_word(12'ha10, w);
        check("pnl_reg_c_value", 64'(w), 64'(model_and(a, b)));
        // unknown code stops before the ADD behind it
        store_word(12'ha30, make_instr(6'd42, 12'ha00, 12'ha01));
        store_word(12'ha31, make_instr(6'd1, 12'ha00, 12'ha01));
        c = rand_word();
        load_c(c);
        run_program(12'ha30);
        check("pnl_strt_value", 64'(pnl_strt_value), 64'(12'ha31));
        check("pnl_op_code", 64'(pnl_op_code), 64'd42);
        check("pnl_reg_c_value", 64'(pnl_reg_c_value), 64'(c));
    endtask

    task automatic output_transfers;
        core_pkg::word_t value;
        core_pkg::mag_t  mag;
        logic [63:0]     digit;
        store_word(12'hb00, make_instr(6'd5, 12'h000, 12'h000));
        store_word(12'hb01, make_instr(6'd0, 12'h000, 12'h000));
        for (int k = 0; k < 2; k++) begin
            if (k == 0) begin
                value = {1'b1, core_pkg::mag_t'(rand_bits(`CORE_MAG_W))};
            end else begin
                value = {1'b0, 30'o1234567012};
            end
            mag = value[`CORE_MAG_W-1:0];
            got_digits.delete();
            load_c(value);
            run_program(12'hb00);
            check("pnl_strt_value", 64'(pnl_strt_value), 64'(12'hb02));
            check("transfer count", 64'(got_digits.size()), 64'(`CORE_OCT_DIGITS + 1));
            check("dev_output_data", 64'(got_digits[0]), 64'(value[`CORE_MAG_W]));
            for (int d = 1; d <= `CORE_OCT_DIGITS; d++) begin
                digit = 64'((mag >> (3 * (`CORE_OCT_DIGITS - d))) & 30'd7);    // msb first
                check("dev_output_data", 64'(got_digits[d]), digit);
            end
        end
    endtask

    initial begin
        arst_n              = 1'b0;
        pnl_start_pulse     = 1'b0;
        pnl_do_arr_c        = 1'b0;
        pnl_arr_reg_c_value = '0;
        pnl_do_arr_strt     = 1'b0;
        pnl_arr_strt_value  = '0;
        pnl_do_arr_sel      = 1'b0;
        pnl_arr_sel_value   = '0;
        pnl_do_store        = 1'b0;
        pnl_do_fetch        = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_reset_state();
        store_fetch_roundtrip();
        add_sub_programs();
        and_write_programs();
        output_transfers();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: core_top.f
+incdir+source
source/core_pkg.sv
source/pulse_unit.sv
source/operator.sv
source/address_unit.sv
source/arith_unit.sv
source/memory.sv
source/io_unit.sv
source/core_top.sv
tb/core_top_sva.sv
tb/core_top_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= core_top_tb
FILELIST   ?= core_top.f
OBJ_DIR    ?= obj_dir
BUILD_JOBS ?= 4
VFLAGS     ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -j $(BUILD_JOBS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
